// ==== src/vga_settings.svh ====
// VGA display settings

`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Horizontal timing in pixel clocks
`define VGA_H_DISP       640
`define VGA_H_FPORCH     16
`define VGA_H_SYNC       96
`define VGA_H_BPORCH     48
`define VGA_H_TOTAL      (`VGA_H_DISP + `VGA_H_FPORCH + `VGA_H_SYNC + `VGA_H_BPORCH)

// Vertical timing in lines
`define VGA_V_DISP       480
`define VGA_V_FPORCH     10
`define VGA_V_SYNC       2
`define VGA_V_BPORCH     33
`define VGA_V_TOTAL      (`VGA_V_DISP + `VGA_V_FPORCH + `VGA_V_SYNC + `VGA_V_BPORCH)

// Width of the scan counters
`define VGA_COUNT_BITS   11

// Image box, centred in the active area
`define VGA_BOX_WIDTH    512
`define VGA_BOX_HEIGHT   448
`define VGA_BOX_H_OFFSET 64
`define VGA_BOX_V_OFFSET 16

// Fetch slots ahead of the first box pixel
`define VGA_FETCH_PRE_FIRST (`VGA_BOX_H_OFFSET - 33)
`define VGA_FETCH_PRE_LAST  (`VGA_BOX_H_OFFSET - 1)
`define VGA_FETCH_WIN_START (`VGA_BOX_H_OFFSET - 16)

// Video memory, one bit per box pixel
`define VRAM_WORDS       7168
`define VRAM_ADDR_BITS   13

`endif

// ==== src/vga_timing_pkg.sv ====
// Scan timing types

`include "vga_settings.svh"
`default_nettype none

package vga_timing_pkg;

   // Counter or position on either axis
   typedef logic [`VGA_COUNT_BITS-1:0] scan_count_t;

   // Registered scan position and flags, one per pixel clock
   typedef struct packed {
      scan_count_t h_count;
      scan_count_t h_pos;       // Pixel index inside the box
      logic        hsync;
      logic        vsync;
      logic        active;
      logic        in_box;
      logic        in_border;
      logic        line_end;    // Last counter value of a line
      logic        fetch_pre;   // Preload slot on a box line
   } scan_state_t;

   // Monitor outputs, all fields aligned to the same pixel
   typedef struct packed {
      logic r;
      logic g;
      logic b;
      logic hsync;
      logic vsync;
      logic blank;
   } vga_out_t;

endpackage

`default_nettype wire

// ==== src/vram_pkg.sv ====
// Video memory types

`include "vga_settings.svh"
`default_nettype none

package vram_pkg;

   typedef logic [`VRAM_ADDR_BITS-1:0] vram_addr_t;

   // 32 pixels, LSB shown first
   typedef logic [31:0] vram_word_t;

   // Host write strobe
   typedef struct packed {
      logic       en;
      vram_addr_t addr;
      vram_word_t data;
   } vram_wr_t;

   // Read answer, one cycle after the request
   typedef struct packed {
      logic       ready;
      vram_word_t data;
   } vram_rd_t;

endpackage

`default_nettype wire

// ==== src/vga_timing.sv ====
// VGA scan timing

`timescale 1ns/1ps
`include "vga_settings.svh"
`default_nettype none

module vga_timing (
   input  wire logic                  vga_clk,
   input  wire logic                  reset,
   output vga_timing_pkg::scan_state_t scan
);

   import vga_timing_pkg::*;

   localparam scan_count_t H_TOTAL     = scan_count_t'(`VGA_H_TOTAL);
   localparam scan_count_t V_TOTAL     = scan_count_t'(`VGA_V_TOTAL);
   localparam scan_count_t HS_START    = scan_count_t'(`VGA_H_DISP + `VGA_H_FPORCH);
   localparam scan_count_t HS_END      = scan_count_t'(`VGA_H_DISP + `VGA_H_FPORCH + `VGA_H_SYNC);
   localparam scan_count_t VS_START    = scan_count_t'(`VGA_V_DISP + `VGA_V_FPORCH);
   localparam scan_count_t VS_END      = scan_count_t'(`VGA_V_DISP + `VGA_V_FPORCH + `VGA_V_SYNC);
   localparam scan_count_t H_BOX_START = scan_count_t'(`VGA_BOX_H_OFFSET);
   localparam scan_count_t H_BOX_END   = scan_count_t'(`VGA_BOX_H_OFFSET + `VGA_BOX_WIDTH);
   localparam scan_count_t V_BOX_START = scan_count_t'(`VGA_BOX_V_OFFSET);
   localparam scan_count_t V_BOX_END   = scan_count_t'(`VGA_BOX_V_OFFSET + `VGA_BOX_HEIGHT);
   localparam scan_count_t PRE_FIRST   = scan_count_t'(`VGA_FETCH_PRE_FIRST);
   localparam scan_count_t PRE_LAST    = scan_count_t'(`VGA_FETCH_PRE_LAST);

   scan_count_t h_cnt;
   scan_count_t v_cnt;
   logic        line_end;
   logic        active;
   logic        h_in_box;
   logic        v_in_box;
   logic        h_edge;
   logic        v_edge;
   logic        h_span;
   logic        v_span;
   scan_state_t scan_next;

   //////////////////////////////////////////////////////////////
   // Counters

   assign line_end = (h_cnt == H_TOTAL - 1'b1);

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (line_end) begin
         h_cnt <= '0;
         if (v_cnt == V_TOTAL - 1'b1)
            v_cnt <= '0;
         else
            v_cnt <= v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////
   // Area flags

   assign active   = (h_cnt < `VGA_H_DISP) && (v_cnt < `VGA_V_DISP);
   assign h_in_box = (h_cnt >= H_BOX_START) && (h_cnt < H_BOX_END);
   assign v_in_box = (v_cnt >= V_BOX_START) && (v_cnt < V_BOX_END);

   // Border ring one pixel outside the box
   assign h_edge = (h_cnt == H_BOX_START - 1'b1) || (h_cnt == H_BOX_END);
   assign v_edge = (v_cnt == V_BOX_START - 1'b1) || (v_cnt == V_BOX_END);
   assign h_span = (h_cnt >= H_BOX_START - 1'b1) && (h_cnt <= H_BOX_END);
   assign v_span = (v_cnt >= V_BOX_START - 1'b1) && (v_cnt <= V_BOX_END);

   always_comb begin
      scan_next           = '0;
      scan_next.h_count   = h_cnt;
      scan_next.h_pos     = h_in_box ? h_cnt - H_BOX_START : '0;
      scan_next.hsync     = (h_cnt >= HS_START) && (h_cnt < HS_END);
      scan_next.vsync     = (v_cnt >= VS_START) && (v_cnt < VS_END);
      scan_next.active    = active;
      scan_next.in_box    = active && h_in_box && v_in_box;
      scan_next.in_border = active && ((h_edge && v_span) || (v_edge && h_span));
      scan_next.line_end  = line_end;
      scan_next.fetch_pre = v_in_box && ((h_cnt == PRE_FIRST) || (h_cnt == PRE_LAST));
   end

   // One cycle behind the counters
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset)
         scan <= '0;
      else
         scan <= scan_next;
   end

   a_count_range: assert property (@(posedge vga_clk) disable iff (reset)
      (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL));

endmodule

`default_nettype wire

// ==== src/vga_scanout.sv ====
// VRAM fetch and pixel output

`timescale 1ns/1ps
`include "vga_settings.svh"
`default_nettype none

module vga_scanout (
   input  wire logic                   vga_clk,
   input  wire logic                   reset,
   input  wire vga_timing_pkg::scan_state_t scan,
   output logic                        vram_req,
   output vram_pkg::vram_addr_t        vram_addr,
   input  wire vram_pkg::vram_rd_t     vram_rd,
   output vga_timing_pkg::vga_out_t    vga
);

   import vga_timing_pkg::*;
   import vram_pkg::*;

   localparam scan_count_t PRE_LAST  = scan_count_t'(`VGA_FETCH_PRE_LAST);
   localparam scan_count_t WIN_START = scan_count_t'(`VGA_FETCH_WIN_START);
   localparam scan_count_t BOX_START = scan_count_t'(`VGA_BOX_H_OFFSET);
   localparam scan_count_t LAST_POS  = scan_count_t'(`VGA_BOX_WIDTH - 1);

   vram_word_t hold_q;
   vram_word_t shift_q;
   logic       hold_empty;
   logic       line_fetch;
   logic       load;
   logic       pre_last;
   logic       addr_inc;
   logic       fetch_window;
   logic       req_next;
   logic       pixel;

   //////////////////////////////////////////////////////////////
   // Load and fetch control

   assign pre_last = scan.fetch_pre && (scan.h_count == PRE_LAST);

   // Word boundary is the last pixel of each 32
   assign load = scan.fetch_pre || (scan.in_box && (scan.h_pos[4:0] == 5'h1f));

   // Step once at the final preload, never on the last load of a line
   assign addr_inc = load && (scan.in_box || pre_last) && (scan.h_pos != LAST_POS);

   always_comb begin
      if (scan.in_box)
         fetch_window = line_fetch && (scan.h_pos[4:0] >= 5'd15);
      else
         fetch_window = line_fetch && (scan.h_count >= WIN_START)
                        && (scan.h_count < BOX_START);
   end

   // One outstanding read at a time
   assign req_next = fetch_window && hold_empty && !vram_req && !vram_rd.ready;

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         vram_req   <= 1'b0;
         hold_empty <= 1'b1;
         line_fetch <= 1'b0;
      end else begin
         vram_req <= req_next;
         if (load)
            hold_empty <= 1'b1;
         else if (vram_rd.ready)
            hold_empty <= 1'b0;
         // Set by the first preload, held to the end of the line
         if (scan.line_end)
            line_fetch <= 1'b0;
         else if (scan.fetch_pre)
            line_fetch <= 1'b1;
      end
   end

   // Row-major word address
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset)
         vram_addr <= '0;
      else if (scan.line_end && !line_fetch)
         vram_addr <= '0;
      else if (addr_inc)
         vram_addr <= vram_addr + 1'b1;
   end

   //////////////////////////////////////////////////////////////
   // Hold and shift registers

   always_ff @(posedge vga_clk) begin
      if (vram_rd.ready && hold_empty)
         hold_q <= vram_rd.data;
   end

   always_ff @(posedge vga_clk) begin
      if (load)
         shift_q <= hold_q;
      else
         shift_q <= {1'b0, shift_q[31:1]};
   end

   //////////////////////////////////////////////////////////////
   // Output stage

   assign pixel = scan.in_box ? shift_q[0] : scan.in_border;

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         vga.r     <= 1'b0;
         vga.g     <= 1'b0;
         vga.b     <= 1'b0;
         vga.hsync <= 1'b0;
         vga.vsync <= 1'b0;
         vga.blank <= 1'b1;
      end else begin
         vga.r     <= pixel;
         vga.g     <= pixel;
         vga.b     <= pixel;
         vga.hsync <= scan.hsync;
         vga.vsync <= scan.vsync;
         vga.blank <= !scan.active;
      end
   end

   // Fetch must keep up with the box pixels
   a_hold_full: assert property (@(posedge vga_clk) disable iff (reset)
      (load && scan.in_box) |-> !hold_empty);

   a_ready_after_req: assert property (@(posedge vga_clk) disable iff (reset)
      vram_rd.ready |-> $past(vram_req));

endmodule

`default_nettype wire

// ==== src/vram.sv ====
// Video RAM

`timescale 1ns/1ps
`include "vga_settings.svh"
`default_nettype none

module vram (
   input  wire logic                 vga_clk,
   input  wire logic                 reset,
   input  wire vram_pkg::vram_wr_t   wr,
   input  wire logic                 req,
   input  wire vram_pkg::vram_addr_t addr,
   output vram_pkg::vram_rd_t        rd
);

   import vram_pkg::*;

   vram_word_t mem [`VRAM_WORDS];
   vram_word_t rd_data_q;
   logic       rd_ready_q;
   logic       rd_in_range;
   logic       wr_in_range;

   assign rd_in_range = (addr < `VRAM_WORDS);
   assign wr_in_range = (wr.addr < `VRAM_WORDS);

   always_ff @(posedge vga_clk) begin
      if (wr.en && wr_in_range)
         mem[wr.addr] <= wr.data;
   end

   // Read sees the old word on a same-cycle write
   always_ff @(posedge vga_clk) begin
      if (req)
         rd_data_q <= rd_in_range ? mem[addr] : '0;
   end

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset)
         rd_ready_q <= 1'b0;
      else
         rd_ready_q <= req;
   end

   assign rd.ready = rd_ready_q;
   assign rd.data  = rd_data_q;

endmodule

`default_nettype wire

// ==== src/vga_display_top.sv ====
// VGA display top level

`timescale 1ns/1ps
`default_nettype none

module vga_display_top (
   input  wire logic               vga_clk,
   input  wire logic               reset,
   input  wire vram_pkg::vram_wr_t host_wr,
   output vga_timing_pkg::vga_out_t vga
);

   import vga_timing_pkg::*;
   import vram_pkg::*;

   logic        local_reset;
   logic        reset_pipe;
   scan_state_t scan;
   logic        vram_req;
   vram_addr_t  vram_addr;
   vram_rd_t    vram_rd;

   //////////////////////////////////////////////////////////////
   // Reset synchroniser

   // Asserts at once, releases two clocks later
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         local_reset <= 1'b1;
         reset_pipe  <= 1'b1;
      end else begin
         local_reset <= reset_pipe;
         reset_pipe  <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////
   // Blocks

   vga_timing vga_timing_i (
      .vga_clk (vga_clk),
      .reset   (local_reset),
      .scan    (scan)
   );

   vga_scanout vga_scanout_i (
      .vga_clk   (vga_clk),
      .reset     (local_reset),
      .scan      (scan),
      .vram_req  (vram_req),
      .vram_addr (vram_addr),
      .vram_rd   (vram_rd),
      .vga       (vga)
   );

   // Host writes share the pixel clock
   vram vram_i (
      .vga_clk (vga_clk),
      .reset   (local_reset),
      .wr      (host_wr),
      .req     (vram_req),
      .addr    (vram_addr),
      .rd      (vram_rd)
   );

endmodule

`default_nettype wire

// ==== dv/vga_display_tb.sv ====
// VGA display testbench

`timescale 1ns/1ps
`include "vga_settings.svh"
`default_nettype none

module vga_display_tb;

   import vga_timing_pkg::*;
   import vram_pkg::*;

   localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
   localparam int BOX_LEFT     = `VGA_BOX_H_OFFSET;
   localparam int BOX_TOP      = `VGA_BOX_V_OFFSET;
   localparam int BOX_RIGHT    = `VGA_BOX_H_OFFSET + `VGA_BOX_WIDTH;
   localparam int BOX_BOTTOM   = `VGA_BOX_V_OFFSET + `VGA_BOX_HEIGHT;

   logic        vga_clk;
   logic        reset;
   vram_wr_t    host_wr;
   vga_out_t    vga;
   vram_word_t  image [`VRAM_WORDS];
   logic [31:0] lfsr = 32'd76;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycles = 0;
   int          cycle_limit = 1000;
   string       rec_name[$];
   string       rec_mode[$];
   vram_word_t  rec_pattern[$];
   int          rec_active[$];
   int          rec_hsync[$];
   int          rec_lit[$];

   vga_display_top vga_display_top_i (
      .vga_clk (vga_clk),
      .reset   (reset),
      .host_wr (host_wr),
      .vga     (vga)
   );

   initial vga_clk = 1'b0;
   always #2 vga_clk = ~vga_clk;

   ////////////////////////////////////////////////////////////
   // Helpers

   // Taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   function automatic vram_word_t random_word();
      vram_word_t word;
      for (int i = 0; i < 32; i++) begin
         lfsr = lfsr_next(lfsr);
         word[i] = lfsr[0];
      end
      return word;
   endfunction

   function automatic logic in_box(input int row, input int col);
      return col >= BOX_LEFT && col < BOX_RIGHT && row >= BOX_TOP && row < BOX_BOTTOM;
   endfunction

   // Image bit inside the box, one-pixel ring just outside it
   function automatic logic expected_pixel(input int row, input int col);
      vram_word_t word;
      int         x;
      int         y;
      x = col - BOX_LEFT;
      y = row - BOX_TOP;
      if (in_box(row, col)) begin
         word = image[vram_addr_t'(y * (`VGA_BOX_WIDTH / 32) + x / 32)];
         return word[5'(x % 32)];
      end
      return ((col == BOX_LEFT - 1 || col == BOX_RIGHT) && row >= BOX_TOP - 1
              && row <= BOX_BOTTOM)
          || ((row == BOX_TOP - 1 || row == BOX_BOTTOM) && col >= BOX_LEFT - 1
              && col <= BOX_RIGHT);
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual) begin
         value_errors++;
         $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic finish_run();
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   endtask

   task automatic wait_vsync_rise();
      logic last;
      last = vga.vsync;
      forever begin
         @(negedge vga_clk);
         if (vga.vsync && !last)
            break;
         last = vga.vsync;
      end
   endtask

   // Host writes, model updated alongside
   task automatic write_image(input string mode, input vram_word_t pattern);
      vram_word_t word;
      for (int a = 0; a < `VRAM_WORDS; a++) begin
         if (mode == "addr")
            word = vram_word_t'(a);
         else if (mode == "random")
            word = random_word();
         else
            word = pattern;
         image[vram_addr_t'(a)] = word;
         @(negedge vga_clk);
         host_wr.en   = 1'b1;
         host_wr.addr = vram_addr_t'(a);
         host_wr.data = word;
      end
      @(negedge vga_clk);
      host_wr.en = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Frame checker, from one vsync rise to the next

   task automatic check_frame(input string name, input int rec);
      vga_out_t prev;
      logic     want;
      int       n = 0;
      int       run = 0;
      int       runs = 0;
      int       h_rises = 0;
      int       h_width = 0;
      int       h_since = -1;
      int       v_high = 0;
      int       lit = 0;
      int       bad = 0;
      int       frame_len = 0;
      prev = vga;
      forever begin
         @(negedge vga_clk);
         frame_len++;
         if (vga.vsync)
            v_high++;
         if (vga.hsync && !prev.hsync) begin
            if (h_since >= 0)
               check_value({name, " hsync period"}, `VGA_H_TOTAL, h_since);
            h_rises++;
            h_since = 0;
            h_width = 0;
         end
         if (!vga.hsync && prev.hsync)
            check_value({name, " hsync width"}, `VGA_H_SYNC, h_width);
         if (vga.hsync)
            h_width++;
         if (h_since >= 0)
            h_since++;
         // Pixel place comes from the count of active cycles
         if (!vga.blank) begin
            want = expected_pixel(n / `VGA_H_DISP, n % `VGA_H_DISP);
            if ({vga.r, vga.g, vga.b} != {3{want}}) begin
               if (bad == 0)
                  check_value($sformatf("%s pixel row %0d col %0d", name,
                     n / `VGA_H_DISP, n % `VGA_H_DISP), int'({3{want}}),
                     int'({vga.r, vga.g, vga.b}));
               bad++;
            end
            if (vga.r && !in_box(n / `VGA_H_DISP, n % `VGA_H_DISP))
               lit++;
            n++;
            run++;
         end else if (!prev.blank) begin
            check_value({name, " line length"}, `VGA_H_DISP, run);
            runs++;
            run = 0;
         end
         if (vga.vsync && !prev.vsync)
            break;
         prev = vga;
      end
      check_value({name, " frame length"}, FRAME_CYCLES, frame_len);
      check_value({name, " vsync width"}, `VGA_V_SYNC * `VGA_H_TOTAL, v_high);
      check_value({name, " hsync pulses"}, rec_hsync[rec], h_rises);
      check_value({name, " active pixels"}, rec_active[rec], n);
      check_value({name, " active lines"}, `VGA_V_DISP, runs);
      check_value({name, " lit outside box"}, rec_lit[rec], lit);
      check_value({name, " pixel mismatches"}, 0, bad);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence

   task automatic run_tests();
      repeat (8) @(negedge vga_clk);
      reset = 1'b0;
      wait_vsync_rise();
      // New image goes in during vertical blank
      foreach (rec_name[i]) begin
         $display("Running %s", rec_name[i]);
         fork
            write_image(rec_mode[i], rec_pattern[i]);
            check_frame(rec_name[i], i);
         join
      end
      $display("Running reset_mid_frame");
      repeat (FRAME_CYCLES / 2) @(negedge vga_clk);
      reset = 1'b1;
      repeat (8) begin
         @(negedge vga_clk);
         // Only blank high
         check_value("reset_mid_frame outputs", 1, int'(vga));
      end
      reset = 1'b0;
      wait_vsync_rise();
      check_frame("reset_mid_frame", rec_name.size() - 1);
   endtask

   always @(posedge vga_clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         other_errors++;
         $display("Timeout: the run did not end within %0d cycles", cycle_limit);
         finish_run();
      end
   end

   initial begin
      int         fd;
      string      line;
      string      name;
      string      mode;
      vram_word_t pattern;
      int         active;
      int         hsync;
      int         lit;
      reset   = 1'b1;
      host_wr = '0;
      fd = $fopen("dv/vga_stim.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Cannot open the stimulus file dv/vga_stim.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#"
                && $sscanf(line, "%s %s %h %d %d %d", name, mode, pattern,
                           active, hsync, lit) == 6) begin
               if (mode != "const" && mode != "addr" && mode != "random") begin
                  other_errors++;
                  $display("Record %s has an unknown fill mode %s", name, mode);
               end
               rec_name.push_back(name);
               rec_mode.push_back(mode);
               rec_pattern.push_back(pattern);
               rec_active.push_back(active);
               rec_hsync.push_back(hsync);
               rec_lit.push_back(lit);
            end
         end
         $fclose(fd);
         // Two frames per record cover the wait for vsync and the checked frame
         cycle_limit = rec_name.size() * 2 * FRAME_CYCLES + 1000;
         run_tests();
      end
      finish_run();
   end

endmodule

`default_nettype wire

// ==== dv/vga_stim.txt ====
# name fill_mode pattern_hex active_pixels hsync_pulses lit_outside_box
# fill_mode: const uses the pattern, addr stores each word's address, random uses the LFSR
blank_image     const   00000000  307200  525  1924
full_image      const   ffffffff  307200  525  1924
stripes         const   aaaaaaaa  307200  525  1924
lsb_only        const   00000001  307200  525  1924
msb_only        const   80000000  307200  525  1924
address_words   addr    00000000  307200  525  1924
random_image    random  00000000  307200  525  1924
random_again    random  00000000  307200  525  1924

// ==== build.f ====
+incdir+src
src/vga_timing_pkg.sv
src/vram_pkg.sv
src/vga_timing.sv
src/vga_scanout.sv
src/vram.sv
src/vga_display_top.sv
dv/vga_display_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := vga_display_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
